/* source/soc_consts.svh */
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// bus widths
`define ADDR_W 16
`define DATA_W 32

// internal memory, 256 words
`define MEM_ADDR_W 10
`define BOOT_WORDS 16

// peripheral slots, field sits just below the address msb
`define N_SLAVES_W 2
`define UART_SLOT 0
`define SOFT_RESET_SLOT 1

// clocks per serial bit
`define UART_DIV 8
`define SOFT_RST_CYCLES 16

`endif

/* source/soc_pkg.sv */
`default_nettype none

`include "soc_consts.svh"

package soc_pkg;

   typedef logic [`ADDR_W-1:0] addr_t;
   typedef logic [`DATA_W-1:0] data_t;
   // zero strobes means read
   typedef logic [`DATA_W/8-1:0] wstrb_t;

   typedef struct packed {
      addr_t  addr;
      data_t  wdata;
      wstrb_t wstrb;
      logic   valid;
   } bus_req_t;

   typedef struct packed {
      data_t rdata;
      logic  ready;
   } bus_rsp_t;

   typedef enum logic [1:0] {
      st_idle,
      st_start,
      st_data,
      st_stop
   } uart_state_e;

endpackage

`default_nettype wire

/* source/baud_timer.sv */
`default_nettype none

`include "soc_consts.svh"

module baud_timer #(
   // cycles from restart to the first tick
   parameter int FIRST = `UART_DIV / 2
) (
   input  wire  clk,
   input  wire  arst_n,
   input  wire  restart,
   output logic tick
);

   localparam int CNT_W = $clog2(`UART_DIV);

   logic [CNT_W-1:0] cnt;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt <= CNT_W'(`UART_DIV - 1);
      end else if (restart) begin
         cnt <= CNT_W'(FIRST - 1);
      end else if (cnt == '0) begin
         cnt <= CNT_W'(`UART_DIV - 1);
      end else begin
         cnt <= cnt - 1'b1;
      end
   end

   assign tick = (cnt == '0);

endmodule

`default_nettype wire

/* source/bus_decoder.sv */
`default_nettype none

`include "soc_consts.svh"

module bus_decoder import soc_pkg::*; (
   input  wire      clk,
   input  wire      arst_n,
   input  bus_req_t m_req,
   output bus_rsp_t m_rsp,
   output bus_req_t mem_req,
   input  bus_rsp_t mem_rsp,
   output bus_req_t uart_req,
   input  bus_rsp_t uart_rsp,
   output bus_req_t rst_req,
   input  bus_rsp_t rst_rsp
);

   logic                   periph;
   logic [`N_SLAVES_W-1:0] slot;
   logic                   uart_sel;
   logic                   rst_sel;
   logic                   unm_sel;
   logic                   unm_ready;

   // msb picks the peripheral region
   assign periph   = m_req.addr[`ADDR_W-1];
   assign slot     = m_req.addr[`ADDR_W-2 -: `N_SLAVES_W];
   assign uart_sel = periph && (slot == `N_SLAVES_W'(`UART_SLOT));
   assign rst_sel  = periph && (slot == `N_SLAVES_W'(`SOFT_RESET_SLOT));
   assign unm_sel  = periph && !uart_sel && !rst_sel;

   always_comb begin
      mem_req        = m_req;
      mem_req.valid  = m_req.valid & ~periph;
      uart_req       = m_req;
      uart_req.valid = m_req.valid & uart_sel;
      rst_req        = m_req;
      rst_req.valid  = m_req.valid & rst_sel;
   end

   // responder for empty slots
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         unm_ready <= 1'b0;
      end else begin
         unm_ready <= m_req.valid & unm_sel & ~unm_ready;
      end
   end

   // address is held until ready, so steer on it directly
   always_comb begin
      if (!periph) begin
         m_rsp = mem_rsp;
      end else if (uart_sel) begin
         m_rsp = uart_rsp;
      end else if (rst_sel) begin
         m_rsp = rst_rsp;
      end else begin
         m_rsp = '{rdata: '0, ready: unm_ready};
      end
   end

endmodule

`default_nettype wire

/* source/int_mem.sv */
`default_nettype none

`include "soc_consts.svh"

module int_mem import soc_pkg::*; (
   input  wire      clk,
   input  bus_req_t req,
   output bus_rsp_t rsp,
   input  wire      boot
);

   localparam int WORDS = 2 ** (`MEM_ADDR_W - 2);

   data_t                   mem [0:WORDS-1];
   logic [`MEM_ADDR_W-3:0]  idx;
   logic                    acc;
   logic                    protect;
   logic                    ready_q;
   data_t                   rdata_q;

   // boot image
   initial begin
      $readmemh("source/boot.hex", mem, 0, `BOOT_WORDS - 1);
   end

   assign idx     = req.addr[`MEM_ADDR_W-1:2];
   assign acc     = req.valid & ~ready_q;
   // boot words are read only until boot drops
   assign protect = boot && (idx < `BOOT_WORDS);

   always_ff @(posedge clk) begin
      if (acc && !protect) begin
         for (int b = 0; b < `DATA_W / 8; b++) begin
            if (req.wstrb[b]) begin
               mem[idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
            end
         end
      end
      if (acc) begin
         rdata_q <= mem[idx];
      end
   end

   // one-cycle ready pulse
   always_ff @(posedge clk) begin
      ready_q <= acc;
   end

   assign rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

`default_nettype wire

/* source/rst_ctr.sv */
`default_nettype none

`include "soc_consts.svh"

module rst_ctr import soc_pkg::*; (
   input  wire      clk,
   input  wire      arst_n,
   input  bus_req_t req,
   output bus_rsp_t rsp,
   output logic     soft_rst,
   output logic     boot
);

   localparam int CNT_W = $clog2(`SOFT_RST_CYCLES + 1);

   logic             acc;
   logic             ready_q;
   logic             boot_q;
   logic [CNT_W-1:0] cnt;
   data_t            rdata_q;

   assign acc = req.valid & ~ready_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ready_q <= 1'b0;
         boot_q  <= 1'b1;
         cnt     <= '0;
      end else begin
         ready_q <= acc;
         // write of bit0 leaves boot and fires the soft reset
         if (acc && (|req.wstrb) && req.wdata[0]) begin
            boot_q <= 1'b0;
            cnt    <= CNT_W'(`SOFT_RST_CYCLES);
         end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (acc) begin
         rdata_q <= {{(`DATA_W-1){1'b0}}, boot_q};
      end
   end

   assign soft_rst = (cnt != '0);
   assign boot     = boot_q;
   assign rsp      = '{rdata: rdata_q, ready: ready_q};

endmodule

`default_nettype wire

/* source/uart_core.sv */
`default_nettype none

`include "soc_consts.svh"

module uart_core import soc_pkg::*; (
   input  wire      clk,
   input  wire      arst_n,
   input  bus_req_t req,
   output bus_rsp_t rsp,
   output logic     txd,
   input  wire      rxd
);

   logic [2:0]  reg_sel;
   logic        acc;
   logic        wr;
   logic        ready_q;
   data_t       rdata_q;
   uart_state_e tx_state;
   uart_state_e rx_state;
   logic [7:0]  tx_shift;
   logic [7:0]  rx_shift;
   logic [7:0]  rx_data;
   logic [2:0]  tx_bit;
   logic [2:0]  rx_bit;
   logic        tx_restart;
   logic        rx_restart;
   logic        tx_tick;
   logic        rx_tick;
   logic        txd_q;
   logic        tx_busy;
   logic        rx_valid;
   logic        rx_done;
   logic        rx_clear;
   logic [1:0]  rxd_sync;

   assign reg_sel    = req.addr[4:2];
   assign acc        = req.valid & ~ready_q;
   assign wr         = |req.wstrb;
   assign tx_busy    = (tx_state != st_idle);
   // writes while busy are dropped
   assign tx_restart = acc & wr & (reg_sel == 3'd0) & ~tx_busy;
   assign rx_restart = (rx_state == st_idle) & ~rxd_sync[1];
   assign rx_clear   = acc & ~wr & (reg_sel == 3'd2);
   assign rx_done    = (rx_state == st_stop) & rx_tick & rxd_sync[1];

   baud_timer #(.FIRST(`UART_DIV)) i_tx_timer (
      .clk     (clk),
      .arst_n  (arst_n),
      .restart (tx_restart),
      .tick    (tx_tick)
   );

   // first rx tick lands mid-bit
   baud_timer #(.FIRST(`UART_DIV / 2)) i_rx_timer (
      .clk     (clk),
      .arst_n  (arst_n),
      .restart (rx_restart),
      .tick    (rx_tick)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ready_q  <= 1'b0;
         rx_valid <= 1'b0;
         rxd_sync <= 2'b11;
      end else begin
         ready_q  <= acc;
         rxd_sync <= {rxd_sync[0], rxd};
         if (rx_clear) begin
            rx_valid <= 1'b0;
         end
         if (rx_done) begin
            rx_valid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (acc) begin
         case (reg_sel)
            3'd1:    rdata_q <= {{(`DATA_W-2){1'b0}}, rx_valid, tx_busy};
            3'd2:    rdata_q <= {{(`DATA_W-8){1'b0}}, rx_data};
            default: rdata_q <= '0;
         endcase
      end
   end

   // transmitter, lsb first
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx_state <= st_idle;
         tx_bit   <= '0;
         txd_q    <= 1'b1;
      end else begin
         case (tx_state)
            st_idle: begin
               if (tx_restart) begin
                  tx_state <= st_start;
                  txd_q    <= 1'b0;
               end
            end
            st_start: begin
               if (tx_tick) begin
                  tx_state <= st_data;
                  tx_bit   <= '0;
                  txd_q    <= tx_shift[0];
               end
            end
            st_data: begin
               if (tx_tick) begin
                  tx_bit <= tx_bit + 1'b1;
                  if (tx_bit == 3'd7) begin
                     tx_state <= st_stop;
                     txd_q    <= 1'b1;
                  end else begin
                     txd_q <= tx_shift[1];
                  end
               end
            end
            default: begin
               if (tx_tick) begin
                  tx_state <= st_idle;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (tx_restart) begin
         tx_shift <= req.wdata[7:0];
      end else if ((tx_state == st_data) && tx_tick) begin
         tx_shift <= {1'b0, tx_shift[7:1]};
      end
   end

   // receiver
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rx_state <= st_idle;
         rx_bit   <= '0;
      end else begin
         case (rx_state)
            st_idle: begin
               if (rx_restart) begin
                  rx_state <= st_start;
               end
            end
            st_start: begin
               if (rx_tick) begin
                  // glitch, not a real start bit
                  rx_state <= rxd_sync[1] ? st_idle : st_data;
                  rx_bit   <= '0;
               end
            end
            st_data: begin
               if (rx_tick) begin
                  rx_bit <= rx_bit + 1'b1;
                  if (rx_bit == 3'd7) begin
                     rx_state <= st_stop;
                  end
               end
            end
            default: begin
               if (rx_tick) begin
                  rx_state <= st_idle;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((rx_state == st_data) && rx_tick) begin
         rx_shift <= {rxd_sync[1], rx_shift[7:1]};
      end
      if (rx_done) begin
         rx_data <= rx_shift;
      end
   end

   assign txd = txd_q;
   assign rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

`default_nettype wire

/* source/soc_system.sv */
`default_nettype none

module soc_system import soc_pkg::*; (
   input  wire      clk,
   input  wire      arst_n,
   input  bus_req_t bus_req,
   output bus_rsp_t bus_rsp,
   output logic     uart_txd,
   input  wire      uart_rxd
);

   bus_req_t mem_req;
   bus_rsp_t mem_rsp;
   bus_req_t uart_req;
   bus_rsp_t uart_rsp;
   bus_req_t rst_req;
   bus_rsp_t rst_rsp;
   logic     soft_rst;
   logic     boot;
   logic     rst_int_n;

   // soft reset also clears decoder and uart
   assign rst_int_n = arst_n & ~soft_rst;

   bus_decoder i_bus_decoder (
      .clk      (clk),
      .arst_n   (rst_int_n),
      .m_req    (bus_req),
      .m_rsp    (bus_rsp),
      .mem_req  (mem_req),
      .mem_rsp  (mem_rsp),
      .uart_req (uart_req),
      .uart_rsp (uart_rsp),
      .rst_req  (rst_req),
      .rst_rsp  (rst_rsp)
   );

   int_mem i_int_mem (
      .clk  (clk),
      .req  (mem_req),
      .rsp  (mem_rsp),
      .boot (boot)
   );

   // kept on the external reset so boot survives a soft reset
   rst_ctr i_rst_ctr (
      .clk      (clk),
      .arst_n   (arst_n),
      .req      (rst_req),
      .rsp      (rst_rsp),
      .soft_rst (soft_rst),
      .boot     (boot)
   );

   uart_core i_uart_core (
      .clk    (clk),
      .arst_n (rst_int_n),
      .req    (uart_req),
      .rsp    (uart_rsp),
      .txd    (uart_txd),
      .rxd    (uart_rxd)
   );

endmodule

`default_nettype wire

/* dv/soc_assertions.sv */
`default_nettype none

`include "soc_consts.svh"

module soc_assertions import soc_pkg::*; (
   input wire      clk,
   input wire      arst_n,
   input bus_req_t bus_req,
   input bus_rsp_t bus_rsp,
   input wire      soft_rst
);

   int unsigned fail_cnt;

   // ready answers the request of the previous cycle
   assert property (@(posedge clk) disable iff (!arst_n)
      bus_rsp.ready |-> $past(bus_req.valid))
      else begin
         fail_cnt++;
         $error("ready without a request in the previous cycle");
      end

   assert property (@(posedge clk) disable iff (!arst_n)
      $rose(bus_req.valid) |=> bus_rsp.ready)
      else begin
         fail_cnt++;
         $error("ready did not follow one cycle after valid");
      end

   // single cycle pulse
   assert property (@(posedge clk) disable iff (!arst_n)
      bus_rsp.ready |=> !bus_rsp.ready)
      else begin
         fail_cnt++;
         $error("ready held for more than one cycle");
      end

   assert property (@(posedge clk) disable iff (!arst_n)
      (bus_req.valid && !bus_rsp.ready) |=> $stable(bus_req))
      else begin
         fail_cnt++;
         $error("request changed while waiting for ready");
      end

   assert property (@(posedge clk) disable iff (!arst_n)
      $rose(soft_rst) |-> soft_rst [*`SOFT_RST_CYCLES] ##1 !soft_rst)
      else begin
         fail_cnt++;
         $error("soft reset pulse has the wrong length");
      end

endmodule

bind soc_system soc_assertions i_soc_assertions (
   .clk      (clk),
   .arst_n   (arst_n),
   .bus_req  (bus_req),
   .bus_rsp  (bus_rsp),
   .soft_rst (soft_rst)
);

`default_nettype wire

/* dv/soc_tb.sv */
`default_nettype none

`include "soc_consts.svh"

module soc_tb import soc_pkg::*; ();

   typedef enum logic [1:0] {op_write, op_read, op_poll, op_idle} op_e;

   // wdata doubles as poll mask and idle count
   typedef struct packed {
      op_e    op;
      addr_t  addr;
      data_t  wdata;
      wstrb_t wstrb;
      data_t  exp;
   } step_t;

   logic        clk;
   logic        arst_n;
   bus_req_t    bus_req;
   bus_rsp_t    bus_rsp;
   wire         serial;
   step_t       steps [$];
   data_t       model [0:255];
   logic        boot_model;
   logic [31:0] rng_state;
   int unsigned cycles;
   int unsigned limit;

   // txd looped back into rxd
   soc_system i_dut (
      .clk      (clk),
      .arst_n   (arst_n),
      .bus_req  (bus_req),
      .bus_rsp  (bus_rsp),
      .uart_txd (serial),
      .uart_rxd (serial)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("error at %0t: run timed out after %0d cycles", $time, cycles);
         $display("TEST FAIL");
         $fatal(1, "timeout");
      end else if (i_dut.i_soc_assertions.fail_cnt != 0) begin
         $display("error at %0t: a bus or soft reset assertion failed", $time);
         $display("TEST FAIL");
         $fatal(1, "assertion failure");
      end
   end

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("TEST FAIL");
         $fatal(1, "first mismatch ends the run");
      end
   endtask

   task automatic push_step(input op_e op, input addr_t addr, input data_t wdata,
                            input wstrb_t wstrb, input data_t exp);
      steps.push_back(step_t'{op: op, addr: addr, wdata: wdata, wstrb: wstrb, exp: exp});
   endtask

   task automatic record_write(input addr_t addr, input data_t data, input wstrb_t strb);
      logic [7:0] idx;
      idx = addr[`MEM_ADDR_W-1:2];
      push_step(op_write, addr, data, strb, '0);
      // boot words keep the file value while boot is set
      if (!(boot_model && idx < `BOOT_WORDS)) begin
         for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
               model[idx][b*8 +: 8] = data[b*8 +: 8];
            end
         end
      end
   endtask

   task automatic expect_read(input addr_t addr);
      push_step(op_read, addr, '0, '0, model[addr[`MEM_ADDR_W-1:2]]);
   endtask

   task automatic build_table();
      addr_t      a;
      addr_t      saved;
      wstrb_t     s;
      logic [7:0] byte_val;
      rng_state  = 32'h5ec6;
      boot_model = 1'b1;
      for (int i = 0; i < `BOOT_WORDS; i++) begin
         model[i] = 32'hb0070000 + i;
      end
      expect_read(16'h0000);
      expect_read(16'h0014);
      expect_read(16'h003c);
      record_write(16'h0014, lcg_next(), 4'hf);
      expect_read(16'h0014);
      push_step(op_read, 16'ha000, '0, '0, 32'd1);
      // words above the boot region
      for (int k = 0; k < 6; k++) begin
         a = addr_t'((`BOOT_WORDS + (lcg_next() >> 16) % 240) * 4);
         record_write(a, lcg_next(), 4'hf);
         s = wstrb_t'(lcg_next() >> 8);
         if (s == '0) begin
            s = 4'b0101;
         end
         record_write(a, lcg_next(), s);
         expect_read(a);
         if (k == 0) begin
            saved = a;
         end
      end
      push_step(op_write, 16'ha000, 32'd1, 4'hf, '0);
      boot_model = 1'b0;
      push_step(op_read, 16'ha000, '0, '0, '0);
      push_step(op_idle, '0, 32'(`SOFT_RST_CYCLES + 4), '0, '0);
      push_step(op_read, 16'ha000, '0, '0, '0);
      record_write(16'h0014, lcg_next(), 4'hf);
      expect_read(16'h0014);
      expect_read(saved);
      // uart loopback
      byte_val = 8'(lcg_next() >> 16);
      push_step(op_write, 16'h8000, {24'h0, byte_val}, 4'b0001, '0);
      push_step(op_poll, 16'h8004, 32'h2, '0, 32'h2);
      push_step(op_read, 16'h8008, '0, '0, {24'h0, byte_val});
      // wait for tx only, rx_valid must already be cleared
      push_step(op_poll, 16'h8004, 32'h1, '0, '0);
      push_step(op_read, 16'h8004, '0, '0, '0);
      push_step(op_read, 16'hc000, '0, '0, '0);
      expect_read(saved);
      limit = steps.size() * (10 * `UART_DIV + 32);
   endtask

   task automatic bus_access(input addr_t addr, input data_t wdata, input wstrb_t wstrb,
                             output data_t rdata);
      int waits;
      waits = 0;
      @(posedge clk);
      bus_req <= '{addr: addr, wdata: wdata, wstrb: wstrb, valid: 1'b1};
      @(negedge clk);
      while (!bus_rsp.ready) begin
         waits++;
         @(negedge clk);
      end
      rdata = bus_rsp.rdata;
      check_value("bus_rsp.ready latency", waits, 1);
      @(posedge clk);
      bus_req <= '0;
   endtask

   initial begin
      data_t rdata;
      arst_n  = 1'b0;
      bus_req = '0;
      build_table();
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check_value("bus_rsp.ready", bus_rsp.ready, 0);
      check_value("uart_txd", serial, 1);
      foreach (steps[i]) begin
         case (steps[i].op)
            op_idle: repeat (steps[i].wdata) @(posedge clk);
            op_write: bus_access(steps[i].addr, steps[i].wdata, steps[i].wstrb, rdata);
            op_poll: begin
               bus_access(steps[i].addr, '0, '0, rdata);
               while ((rdata & steps[i].wdata) != steps[i].exp) begin
                  bus_access(steps[i].addr, '0, '0, rdata);
               end
            end
            default: begin
               bus_access(steps[i].addr, '0, '0, rdata);
               check_value($sformatf("bus_rsp.rdata at addr %h", steps[i].addr),
                           rdata, steps[i].exp);
            end
         endcase
      end
      repeat (2) @(posedge clk);
      if (i_dut.i_soc_assertions.fail_cnt != 0) begin
         $display("error at %0t: %0d assertion failures", $time,
                  i_dut.i_soc_assertions.fail_cnt);
         $display("TEST FAIL");
         $fatal(1, "assertion failure");
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* sim.f */
+incdir+source
source/soc_pkg.sv
source/baud_timer.sv
source/bus_decoder.sv
source/int_mem.sv
source/rst_ctr.sv
source/uart_core.sv
source/soc_system.sv
dv/soc_assertions.sv
dv/soc_tb.sv

/* source/boot.hex */
// boot words 0 to 15, one 32-bit hex word per line
b0070000
b0070001
b0070002
b0070003
b0070004
b0070005
b0070006
b0070007
b0070008
b0070009
b007000a
b007000b
b007000c
b007000d
b007000e
b007000f
